/* vlog.f */
+incdir+hw
hw/tcb_pkg.sv
hw/tcb_if.sv
hw/tcb_dec.sv
hw/tcb_dmx.sv
hw/tcb_mem.sv
hw/tcb_sys.sv
sim/tcb_sys_checker.sv
sim/tcb_sys_tb.sv

/* Bender.yml */
package:
  name: tcb_sys

sources:
  - include_dirs:
      - hw
    files:
      - hw/tcb_pkg.sv
      - hw/tcb_if.sv
      - hw/tcb_dec.sv
      - hw/tcb_dmx.sv
      - hw/tcb_mem.sv
      - hw/tcb_sys.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/tcb_sys_checker.sv
      - sim/tcb_sys_tb.sv

/* sim/tcb_sys_tb.sv */
// tcb memory subsystem testbench
// table driven reads and writes, checked against a scoreboard memory per port

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_sys_tb;
  import tcb_pkg::*;

  localparam int unsigned NSTEP = 34;
  localparam int unsigned BW = `TCB_DW / `TCB_SW;
  localparam int unsigned OW = $clog2(BW);
  // table length x 4 cycles, plus reset
  localparam int unsigned TIMEOUT_NS = (NSTEP * 4 + 3) * 40;

  // one table row
  typedef struct packed {
    logic wen;
    adr_t adr;
    ben_t ben;
    logic exp_err;
  } step_t;

  // expected response of an issued step
  typedef struct packed {
    logic [31:0] k;
    dat_t        rdt;
    logic        err;
  } rsp_t;

  logic sub;
  logic rst_n;
  logic vld;
  logic wen;
  ben_t ben;
  adr_t adr;
  dat_t wdt;
  logic rdy;
  dat_t rdt;
  logic err;

  // scoreboard, one word array per port
  dat_t ref_mem [`TCB_PN][`TCB_MEM_DEPTH];
  rsp_t exp_q [$];
  logic step_bad;
  int unsigned n_pass;
  int unsigned n_fail;

  //////////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////////

  // columns: write enable, address, byte enables, expected error
  step_t steps [NSTEP] = '{
    // full word write then read, every port
    '{1'b1, 32'h0000_0000, 4'hf, 1'b0},
    '{1'b1, 32'h0000_1004, 4'hf, 1'b0},
    '{1'b1, 32'h0000_2008, 4'hf, 1'b0},
    '{1'b1, 32'h0000_300c, 4'hf, 1'b0},
    '{1'b0, 32'h0000_0000, 4'hf, 1'b0},
    '{1'b0, 32'h0000_1004, 4'hf, 1'b0},
    '{1'b0, 32'h0000_2008, 4'hf, 1'b0},
    '{1'b0, 32'h0000_300c, 4'hf, 1'b0},
    // partial writes, merge with old contents
    '{1'b1, 32'h0000_1010, 4'hf, 1'b0},
    '{1'b1, 32'h0000_1010, 4'h5, 1'b0},
    '{1'b0, 32'h0000_1010, 4'hf, 1'b0},
    '{1'b1, 32'h0000_2010, 4'h8, 1'b0},
    '{1'b0, 32'h0000_2010, 4'hf, 1'b0},
    // same offset in every window
    '{1'b1, 32'h0000_0020, 4'hf, 1'b0},
    '{1'b1, 32'h0000_1020, 4'hf, 1'b0},
    '{1'b1, 32'h0000_2020, 4'hf, 1'b0},
    '{1'b1, 32'h0000_3020, 4'hf, 1'b0},
    '{1'b0, 32'h0000_0020, 4'hf, 1'b0},
    '{1'b0, 32'h0000_1020, 4'hf, 1'b0},
    '{1'b0, 32'h0000_2020, 4'hf, 1'b0},
    '{1'b0, 32'h0000_3020, 4'hf, 1'b0},
    // past the implemented depth, aliases of word 0 and word 255
    '{1'b1, 32'h0000_0400, 4'hf, 1'b1},
    '{1'b0, 32'h0000_0400, 4'hf, 1'b1},
    '{1'b0, 32'h0000_0000, 4'hf, 1'b0},
    '{1'b1, 32'h0000_1ffc, 4'hf, 1'b1},
    '{1'b0, 32'h0000_13fc, 4'hf, 1'b0},
    // beyond the last window
    '{1'b1, 32'h0000_4000, 4'hf, 1'b1},
    '{1'b0, 32'h0000_4000, 4'hf, 1'b1},
    '{1'b0, 32'hffff_fff0, 4'hf, 1'b1},
    '{1'b0, 32'h0000_0000, 4'hf, 1'b0},
    // reads hopping across ports
    '{1'b0, 32'h0000_3020, 4'hf, 1'b0},
    '{1'b0, 32'h0000_0020, 4'hf, 1'b0},
    '{1'b0, 32'h0000_2020, 4'hf, 1'b0},
    '{1'b0, 32'h0000_1020, 4'hf, 1'b0}
  };

  tcb_sys tcb_sys_inst (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (vld),
    .wen   (wen),
    .ben   (ben),
    .adr   (adr),
    .wdt   (wdt),
    .rdy   (rdy),
    .rdt   (rdt),
    .err   (err)
  );

  initial begin
    sub = 1'b0;
    forever #20 sub = ~sub;
  end

  //////////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_dat(input dat_t got, input dat_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s rdt %h, expected %h", $time, what, got, exp);
      step_bad = 1'b1;
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s err %b, expected %b", $time, what, got, exp);
      step_bad = 1'b1;
    end
  endtask

  // drive one step and predict its response
  task automatic issue(input int unsigned k);
    int unsigned port;
    int unsigned word;
    dat_t data;
    rsp_t rsp;
    data = $urandom();
    port = steps[k].adr >> `TCB_WIN_LOG;
    word = steps[k].adr[`TCB_WIN_LOG-1:OW];
    vld <= 1'b1;
    wen <= steps[k].wen;
    ben <= steps[k].ben;
    adr <= steps[k].adr;
    wdt <= data;
    rsp.k = k;
    rsp.rdt = '0;
    rsp.err = steps[k].exp_err;
    if (!steps[k].exp_err) begin
      if (steps[k].wen) begin
        for (int unsigned b = 0; b < BW; b++) begin
          if (steps[k].ben[b]) begin
            ref_mem[port][word][b*`TCB_SW +: `TCB_SW] = data[b*`TCB_SW +: `TCB_SW];
          end
        end
      end else begin
        rsp.rdt = ref_mem[port][word];
      end
    end
    exp_q.push_back(rsp);
  endtask

  // oldest expected response against the live outputs
  task automatic check_rsp();
    rsp_t rsp;
    string what;
    rsp = exp_q.pop_front();
    what = $sformatf("step %0d %s %h", rsp.k, steps[rsp.k].wen ? "write" : "read",
                     steps[rsp.k].adr);
    step_bad = 1'b0;
    check_err(err, rsp.err, what);
    if (!steps[rsp.k].wen) begin
      check_dat(rdt, rsp.rdt, what);
    end
    if (step_bad) begin
      n_fail++;
      $display("%s: mismatch", what);
    end else begin
      n_pass++;
      $display("%s: ok", what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h487d_cdde));
    rst_n = 1'b0;
    vld = 1'b0;
    wen = 1'b0;
    ben = '0;
    adr = '0;
    wdt = '0;
    n_pass = 0;
    n_fail = 0;
    for (int p = 0; p < `TCB_PN; p++) begin
      for (int w = 0; w < `TCB_MEM_DEPTH; w++) begin
        ref_mem[p][w] = '0;
      end
    end
    repeat (3) @(posedge sub);
    rst_n <= 1'b1;
    // one step per cycle, previous response checked mid cycle
    for (int unsigned k = 0; k < NSTEP; k++) begin
      @(posedge sub);
      issue(k);
      @(negedge sub);
      if (k > 0) begin
        check_rsp();
      end
      while (!rdy) begin
        @(posedge sub);
        @(negedge sub);
      end
    end
    @(posedge sub);
    vld <= 1'b0;
    @(negedge sub);
    check_rsp();
    @(posedge sub);
    $display("steps: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && n_pass == NSTEP) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, run hung waiting for ready", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule

/* sim/tcb_sys_checker.sv */
// tcb system checker
// concurrent assertions on the top level handshake and response timing

`timescale 1ns/1ps

module tcb_sys_checker (
  input logic          sub,
  input logic          rst_n,
  input logic          vld,
  input logic          wen,
  input tcb_pkg::ben_t ben,
  input tcb_pkg::adr_t adr,
  input tcb_pkg::dat_t wdt,
  input logic          rdy,
  input logic          err
);
  import tcb_pkg::*;

  // request as one word for the stability check
  req_t req;
  logic trn;
  // at least one transfer since reset
  logic seen_trn;

  assign req = {wen, ben, adr, wdt};
  assign trn = vld & rdy;

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      seen_trn <= 1'b0;
    end else if (trn) begin
      seen_trn <= 1'b1;
    end
  end

  err_quiet_after_reset: assert property (
    @(posedge sub) disable iff (!rst_n) !seen_trn |-> !err
  ) else $error("err high before the first transfer");

  req_held_while_waiting: assert property (
    @(posedge sub) disable iff (!rst_n) vld && !rdy |=> vld && $stable(req)
  ) else $error("request changed while waiting for rdy");

  err_only_after_trn: assert property (
    @(posedge sub) disable iff (!rst_n) err |-> $past(trn)
  ) else $error("err high outside the response cycle");

endmodule

bind tcb_sys tcb_sys_checker checker_inst (
  .sub   (sub),
  .rst_n (rst_n),
  .vld   (vld),
  .wen   (wen),
  .ben   (ben),
  .adr   (adr),
  .wdt   (wdt),
  .rdy   (rdy),
  .err   (err)
);

/* hw/tcb_sys.sv */
// tcb memory subsystem top
// one manager port, address decoder, demultiplexer and TCB_PN memories

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_sys (
  input  logic          sub,
  input  logic          rst_n,
  // request
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::dat_t wdt,
  // response
  output logic          rdy,
  output tcb_pkg::dat_t rdt,
  output logic          err
);
  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////////
  // buses
  //////////////////////////////////////////////////////////////////////////

  // upstream, from the top level ports
  tcb_if bus_up (
    .sub   (sub),
    .rst_n (rst_n)
  );

  // downstream, one per memory
  tcb_if bus_dn [`TCB_PN-1:0] (
    .sub   (sub),
    .rst_n (rst_n)
  );

  // decoder to dmx
  sel_t sel;
  logic unmapped;

  // plain ports onto the upstream bus
  assign bus_up.vld     = vld;
  assign bus_up.req.wen = wen;
  assign bus_up.req.ben = ben;
  assign bus_up.req.adr = adr;
  assign bus_up.req.wdt = wdt;

  assign rdy = bus_up.rdy;
  assign rdt = bus_up.rdt;
  assign err = bus_up.err;

  //////////////////////////////////////////////////////////////////////////
  // interconnect
  //////////////////////////////////////////////////////////////////////////

  tcb_dec dec_inst (
    .adr      (bus_up.req.adr),
    .sel      (sel),
    .unmapped (unmapped)
  );

  tcb_dmx dmx_inst (
    .sel      (sel),
    .unmapped (unmapped),
    .up       (bus_up),
    .dn       (bus_dn)
  );

  //////////////////////////////////////////////////////////////////////////
  // memories
  //////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `TCB_PN; i++) begin : gen_mem
    tcb_mem mem_inst (
      .bus (bus_dn[i])
    );
  end : gen_mem

endmodule

/* hw/tcb_mem.sv */
// tcb memory subordinate
// word array with byte enables, read data registered one cycle after trn,
// error response for offsets past the implemented depth

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_mem (
  tcb_if.trg bus
);
  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////////

  // byte lanes per word
  localparam int unsigned BW = `TCB_DW / `TCB_SW;
  // byte address bits inside a word
  localparam int unsigned OW = $clog2(BW);
  // word offset bits inside a window
  localparam int unsigned WW = `TCB_WIN_LOG - OW;
  // implemented word index bits
  localparam int unsigned IW = $clog2(`TCB_MEM_DEPTH);

  //////////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////////

  // storage
  dat_t mem [`TCB_MEM_DEPTH-1:0];

  // word offset inside the window
  logic [WW-1:0] off;
  // index into the implemented words
  logic [IW-1:0] idx;
  // offset past the implemented depth
  logic          oor;

  assign off = bus.req.adr[`TCB_WIN_LOG-1:OW];
  assign idx = off[IW-1:0];
  assign oor = (off >= WW'(`TCB_MEM_DEPTH));

  //////////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////////

  // no wait states
  assign bus.rdy = 1'b1;

  //////////////////////////////////////////////////////////////////////////
  // array and response
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus.sub or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      // small depth, clear the whole array
      for (int unsigned w = 0; w < `TCB_MEM_DEPTH; w++) begin
        mem[w] <= '0;
      end
      bus.rdt <= '0;
      bus.err <= 1'b0;
    end else begin
      // err only in the cycle after a transfer
      bus.err <= bus.trn & oor;
      if (bus.trn) begin
        if (oor) begin
          // array untouched, zero data back
          bus.rdt <= '0;
        end else if (bus.req.wen) begin
          // enabled lanes only
          for (int unsigned b = 0; b < BW; b++) begin
            if (bus.req.ben[b]) begin
              mem[idx][b*`TCB_SW +: `TCB_SW] <= bus.req.wdt[b*`TCB_SW +: `TCB_SW];
            end
          end
        end else begin
          // read, whole word regardless of ben
          bus.rdt <= mem[idx];
        end
      end
    end
  end

endmodule

/* hw/tcb_dmx.sv */
// tcb demultiplexer
// routes requests to one of TCB_PN subordinates, muxes the response back
// using the select registered at the transfer

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_dmx (
  input  tcb_pkg::sel_t sel,
  input  logic          unmapped,
  tcb_if.trg            up,
  tcb_if.mgr            dn [`TCB_PN-1:0]
);
  import tcb_pkg::*;

  genvar i;

  //////////////////////////////////////////////////////////////////////////
  // width check between upstream and downstream interfaces
  //////////////////////////////////////////////////////////////////////////

  for (i = 0; i < `TCB_PN; i++) begin : gen_chk
    if (up.AW != dn[i].AW) begin : gen_aw
      $error("tcb_dmx: address width mismatch on port %0d", i);
    end
    if (up.DW != dn[i].DW) begin : gen_dw
      $error("tcb_dmx: data width mismatch on port %0d", i);
    end
    if (up.BW != dn[i].BW) begin : gen_bw
      $error("tcb_dmx: byte enable width mismatch on port %0d", i);
    end
  end : gen_chk

  //////////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////////

  // select captured on trn, steers the response phase
  sel_t rsp_sel;
  // unmapped transfer in the previous cycle
  logic rsp_unm;

  // responses gathered into plain arrays
  // an interface array cannot take a dynamic index
  dat_t tmp_rdt [`TCB_PN-1:0];
  logic tmp_err [`TCB_PN-1:0];
  logic tmp_rdy [`TCB_PN-1:0];

  //////////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge up.sub or negedge up.rst_n) begin
    if (!up.rst_n) begin
      rsp_sel <= '0;
      rsp_unm <= 1'b0;
    end else begin
      // select only moves on a transfer
      if (up.trn) begin
        rsp_sel <= sel;
      end
      // error flag lives for one cycle only
      rsp_unm <= up.trn & unmapped;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////////

  for (i = 0; i < `TCB_PN; i++) begin : gen_req
    // vld only toward the selected, mapped port
    assign dn[i].vld = (!unmapped && (sel == i)) ? up.vld : 1'b0;
    // unselected ports see garbage
    assign dn[i].req = (sel == i) ? up.req : 'x;
  end : gen_req

  //////////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////////

  for (i = 0; i < `TCB_PN; i++) begin : gen_rsp
    assign tmp_rdt[i] = dn[i].rdt;
    assign tmp_err[i] = dn[i].err;
    assign tmp_rdy[i] = dn[i].rdy;
  end : gen_rsp

  // request phase, live select
  // unmapped space is answered here, never stalls
  assign up.rdy = unmapped ? 1'b1 : tmp_rdy[sel];

  // response phase, registered select
  assign up.rdt = rsp_unm ? '0   : tmp_rdt[rsp_sel];
  assign up.err = rsp_unm ? 1'b1 : tmp_err[rsp_sel];

endmodule

/* hw/tcb_dec.sv */
// tcb address decoder
// maps fixed size address windows onto a port select, flags unmapped space

`timescale 1ns/1ps

`include "tcb_settings.svh"

module tcb_dec (
  input  tcb_pkg::adr_t adr,
  output tcb_pkg::sel_t sel,
  output logic          unmapped
);
  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////////////////////////////

  // window index bits above the per-port window
  localparam int unsigned IW = `TCB_AW - `TCB_WIN_LOG;
  // select width
  localparam int unsigned PL = $bits(sel_t);

  // window index, port i owns base i << TCB_WIN_LOG
  logic [IW-1:0] win;

  // offset below TCB_WIN_LOG goes to the subordinate untouched
  assign win = adr[`TCB_AW-1:`TCB_WIN_LOG];

  //////////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////////

  // anything past the last window
  assign unmapped = (win >= IW'(`TCB_PN));

  // window index is the port number
  // park on port 0 when unmapped, dmx keeps vld away anyway
  always_comb begin
    if (unmapped) begin
      sel = '0;
    end else begin
      sel = win[PL-1:0];
    end
  end

endmodule

/* hw/tcb_if.sv */
// tcb bus interface
// single-beat valid/ready request, response one cycle after the transfer

`timescale 1ns/1ps

interface tcb_if (
  input logic sub,
  input logic rst_n
);
  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////////////////
  // widths, for checks between connected interfaces
  ////////////////////////////////////////////////////////////////////////

  localparam int unsigned AW = $bits(adr_t);
  localparam int unsigned DW = $bits(dat_t);
  localparam int unsigned BW = $bits(ben_t);

  ////////////////////////////////////////////////////////////////////////
  // signals
  ////////////////////////////////////////////////////////////////////////

  // handshake, request phase
  logic vld;
  logic rdy;

  // request payload
  req_t req;

  // response phase, one cycle after trn
  dat_t rdt;
  logic err;

  // transfer happens on this edge
  logic trn;

  assign trn = vld & rdy;

  ////////////////////////////////////////////////////////////////////////
  // modports
  ////////////////////////////////////////////////////////////////////////

  // manager side drives the request
  modport mgr (
    input  sub, rst_n, trn,
    output vld, req,
    input  rdy, rdt, err
  );

  // target side answers
  modport trg (
    input  sub, rst_n, trn,
    input  vld, req,
    output rdy, rdt, err
  );

endinterface

/* hw/tcb_pkg.sv */
// tcb memory subsystem types
// address, data, byte enable and port select types plus the request struct

`include "tcb_settings.svh"

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////////
  // scalar types
  //////////////////////////////////////////////////////////////////////////

  // byte address
  typedef logic [`TCB_AW-1:0] adr_t;

  // data word
  typedef logic [`TCB_DW-1:0] dat_t;

  // one enable per byte lane
  typedef logic [`TCB_DW/`TCB_SW-1:0] ben_t;

  // port select toward the subordinates
  typedef logic [$clog2(`TCB_PN)-1:0] sel_t;

  //////////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////////

  // everything the manager holds stable while waiting for rdy
  typedef struct packed {
    // write enable, read when low
    logic wen;
    // byte enables
    ben_t ben;
    // byte address
    adr_t adr;
    // write data
    dat_t wdt;
  } req_t;

endpackage

/* hw/tcb_settings.svh */
// tcb memory subsystem settings
// bus widths, port count, address window and memory depth

`ifndef TCB_SETTINGS_SVH
`define TCB_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////////////////////

// address width
`define TCB_AW 32
// data width
`define TCB_DW 32
// byte lane width
`define TCB_SW 8

////////////////////////////////////////////////////////////////////////////
// interconnect
////////////////////////////////////////////////////////////////////////////

// number of memory subordinates
`define TCB_PN 4
// log2 of the byte window owned by each port (4 KiB)
`define TCB_WIN_LOG 12

// implemented words per port, rest of window is out of range
`define TCB_MEM_DEPTH 256

`endif
